// File: hw/mipsCore_macros.svh
`ifndef MIPS_CORE_MACROS_SVH
`define MIPS_CORE_MACROS_SVH

// datapath and address width
`define DATA_W 32
`define REG_ADDR_W 5
`define REG_COUNT 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// File: hw/mipsIsaPkg.sv
`default_nettype none
`include "mipsCore_macros.svh"

package mipsIsaPkg;

    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;

    localparam opcodeT opR     = 6'h00;   // SPECIAL, decoded by funct
    localparam opcodeT opAddiu = 6'h09;
    localparam opcodeT opAndi  = 6'h0c;
    localparam opcodeT opOri   = 6'h0d;
    localparam opcodeT opLui   = 6'h0f;
    localparam opcodeT opLw    = 6'h23;
    localparam opcodeT opSw    = 6'h2b;

    localparam functT fnSll  = 6'h00;
    localparam functT fnAddu = 6'h21;
    localparam functT fnSubu = 6'h23;
    localparam functT fnAnd  = 6'h24;
    localparam functT fnOr   = 6'h25;
    localparam functT fnXor  = 6'h26;
    localparam functT fnSlt  = 6'h2a;

    // R-type layout; the I-type immediate is the low 16 bits
    typedef struct packed {
        opcodeT                 opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [4:0]             shamt;
        functT                  funct;
    } instrT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluLui
    } aluOpT;

endpackage

`default_nettype wire

// File: hw/pipeCtrlPkg.sv
`default_nettype none
`include "mipsCore_macros.svh"

package pipeCtrlPkg;
    import mipsIsaPkg::*;

    typedef struct packed {
        logic                   regWrite;
        logic                   memRead;   // LW, also selects load data in W
        logic                   memWrite;
        logic                   aluSrcImm;
        aluOpT                  aluOp;
        logic [`REG_ADDR_W-1:0] writeReg;  // rt or rd already resolved
    } ctrlT;

    typedef struct packed {
        logic [`DATA_W-1:0]     pc;
        ctrlT                   ctrl;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`DATA_W-1:0]     rsData;
        logic [`DATA_W-1:0]     rtData;
        logic [`DATA_W-1:0]     imm;       // already extended
        logic [4:0]             shamt;
    } idExT;

    typedef struct packed {
        logic [`DATA_W-1:0]     pc;
        ctrlT                   ctrl;
        logic [`DATA_W-1:0]     aluResult; // also the data address
        logic [`DATA_W-1:0]     storeData;
    } exMemT;

    // operand source for the E stage
    typedef enum logic [1:0] {
        fwdNone = 2'd0,
        fwdMem  = 2'd1,
        fwdWb   = 2'd2
    } fwdSelT;

endpackage

`default_nettype wire

// File: hw/wbIf.sv
`timescale 1ns/1ps
`default_nettype none
`include "mipsCore_macros.svh"

interface wbIf;
    logic                   regWriteEn;
    logic [`REG_ADDR_W-1:0] writeReg;
    logic [`DATA_W-1:0]     writeData;
    logic [`DATA_W-1:0]     pc;         // retiring instruction, for the trace

    modport src (output regWriteEn, writeReg, writeData, pc);
    modport dst (input regWriteEn, writeReg, writeData, pc);
endinterface

`default_nettype wire

// File: hw/fetchDecode.sv
`timescale 1ns/1ps
`default_nettype none
`include "mipsCore_macros.svh"

module fetchDecode (
    input  wire                         clk,
    input  wire                         rstN_i,
    input  wire                         stall_i,
    output logic [`DATA_W-1:0]          imemAddr_o,
    input  wire  [`DATA_W-1:0]          imemData_i,
    output logic [`REG_ADDR_W-1:0]      rsField_o,
    output logic [`REG_ADDR_W-1:0]      rtField_o,
    output pipeCtrlPkg::idExT           idEx_o,
    wbIf.dst                            wb
);
    import mipsIsaPkg::*;
    import pipeCtrlPkg::*;

    logic [`DATA_W-1:0] pcF;
    logic [`DATA_W-1:0] pcD;
    instrT              instrD;
    ctrlT               ctrlD;
    logic               zeroExt;
    logic [`DATA_W-1:0] immD;
    logic [`DATA_W-1:0] rsDataD;
    logic [`DATA_W-1:0] rtDataD;
    logic [`DATA_W-1:0] regFile [`REG_COUNT];

    assign imemAddr_o = pcF;
    assign rsField_o  = instrD.rs;
    assign rtField_o  = instrD.rt;

    // PC and IF/ID both hold on a load-use stall
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            pcF    <= `RESET_PC;
            instrD <= '0;               // all zeros decodes as nop
        end else if (!stall_i) begin
            pcF    <= pcF + `DATA_W'd4;
            instrD <= imemData_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) pcD <= pcF;
    end

    always_comb begin
        ctrlD       = '0;
        ctrlD.aluOp = aluAdd;
        case (instrD.opcode)
            opR: begin
                ctrlD.regWrite = 1'b1;
                ctrlD.writeReg = instrD.rd;
                case (instrD.funct)
                    fnAddu:  ctrlD.aluOp = aluAdd;
                    fnSubu:  ctrlD.aluOp = aluSub;
                    fnAnd:   ctrlD.aluOp = aluAnd;
                    fnOr:    ctrlD.aluOp = aluOr;
                    fnXor:   ctrlD.aluOp = aluXor;
                    fnSlt:   ctrlD.aluOp = aluSlt;
                    fnSll:   ctrlD.aluOp = aluSll;
                    default: ctrlD.regWrite = 1'b0;  // unsupported funct
                endcase
            end
            opAddiu, opAndi, opOri, opLui, opLw: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.aluSrcImm = 1'b1;
                ctrlD.writeReg  = instrD.rt;
                ctrlD.memRead   = (instrD.opcode == opLw);
                if (instrD.opcode == opAndi) ctrlD.aluOp = aluAnd;
                if (instrD.opcode == opOri)  ctrlD.aluOp = aluOr;
                if (instrD.opcode == opLui)  ctrlD.aluOp = aluLui;
            end
            opSw: begin
                ctrlD.memWrite  = 1'b1;
                ctrlD.aluSrcImm = 1'b1;         // address = rs + offset
            end
            default: ;
        endcase
        // r0 is never written, so drop it here
        if (ctrlD.writeReg == '0) ctrlD.regWrite = 1'b0;
    end

    assign zeroExt = (instrD.opcode == opAndi) || (instrD.opcode == opOri);
    assign immD    = {{(`DATA_W-16){instrD[15] & ~zeroExt}}, instrD[15:0]};

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            regFile <= '{default: '0};
        end else if (wb.regWriteEn) begin
            regFile[wb.writeReg] <= wb.writeData;
        end
    end

    // write-first: same-cycle write-back wins over the stored value
    assign rsDataD = (wb.regWriteEn && wb.writeReg == instrD.rs) ? wb.writeData
                                                                 : regFile[instrD.rs];
    assign rtDataD = (wb.regWriteEn && wb.writeReg == instrD.rt) ? wb.writeData
                                                                 : regFile[instrD.rt];

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            idEx_o <= '0;
        end else begin
            idEx_o.pc     <= pcD;
            idEx_o.ctrl   <= stall_i ? '0 : ctrlD;   // bubble into E
            idEx_o.rs     <= instrD.rs;
            idEx_o.rt     <= instrD.rt;
            idEx_o.rsData <= rsDataD;
            idEx_o.rtData <= rtDataD;
            idEx_o.imm    <= immD;
            idEx_o.shamt  <= instrD.shamt;
        end
    end

endmodule

`default_nettype wire

// File: hw/executeStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "mipsCore_macros.svh"

module executeStage (
    input  wire                         clk,
    input  wire                         rstN_i,
    input  wire pipeCtrlPkg::idExT      idEx_i,
    input  wire pipeCtrlPkg::fwdSelT    fwdA_i,
    input  wire pipeCtrlPkg::fwdSelT    fwdB_i,
    input  wire  [`DATA_W-1:0]          wbData_i,
    output pipeCtrlPkg::exMemT          exMem_o
);
    import mipsIsaPkg::*;
    import pipeCtrlPkg::*;

    logic [`DATA_W-1:0] srcA;
    logic [`DATA_W-1:0] regB;
    logic [`DATA_W-1:0] srcB;
    logic [`DATA_W-1:0] aluResult;

    // M result sits in our own EX/MEM register
    function automatic logic [`DATA_W-1:0] fwdMux(fwdSelT sel, logic [`DATA_W-1:0] regVal,
                                                  logic [`DATA_W-1:0] memVal,
                                                  logic [`DATA_W-1:0] wbVal);
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign srcA = fwdMux(fwdA_i, idEx_i.rsData, exMem_o.aluResult, wbData_i);
    assign regB = fwdMux(fwdB_i, idEx_i.rtData, exMem_o.aluResult, wbData_i);
    assign srcB = idEx_i.ctrl.aluSrcImm ? idEx_i.imm : regB;

    always_comb begin
        case (idEx_i.ctrl.aluOp)
            aluAdd:  aluResult = srcA + srcB;
            aluSub:  aluResult = srcA - srcB;
            aluAnd:  aluResult = srcA & srcB;
            aluOr:   aluResult = srcA | srcB;
            aluXor:  aluResult = srcA ^ srcB;
            aluSlt:  aluResult = {{(`DATA_W-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            aluSll:  aluResult = srcB << idEx_i.shamt;   // rt shifted, rs unused
            aluLui:  aluResult = srcB << 16;
            default: aluResult = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            exMem_o <= '0;
        end else begin
            exMem_o.pc        <= idEx_i.pc;
            exMem_o.ctrl      <= idEx_i.ctrl;
            exMem_o.aluResult <= aluResult;
            exMem_o.storeData <= regB;      // forwarded rt for SW
        end
    end

endmodule

`default_nettype wire

// File: hw/memWbStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "mipsCore_macros.svh"

module memWbStage (
    input  wire                         clk,
    input  wire                         rstN_i,
    input  wire pipeCtrlPkg::exMemT     exMem_i,
    output logic                        dmemEn_o,
    output logic                        dmemWe_o,
    output logic [`DATA_W-1:0]          dmemAddr_o,
    output logic [`DATA_W-1:0]          dmemWriteData_o,
    input  wire  [`DATA_W-1:0]          dmemReadData_i,
    wbIf.src                            wb
);

    logic                   regWriteW;
    logic                   memReadW;
    logic [`REG_ADDR_W-1:0] writeRegW;
    logic [`DATA_W-1:0]     aluResultW;
    logic [`DATA_W-1:0]     readDataW;
    logic [`DATA_W-1:0]     pcW;

    // word accesses only, address straight from the ALU
    assign dmemEn_o        = exMem_i.ctrl.memRead | exMem_i.ctrl.memWrite;
    assign dmemWe_o        = exMem_i.ctrl.memWrite;
    assign dmemAddr_o      = exMem_i.aluResult;
    assign dmemWriteData_o = exMem_i.storeData;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            regWriteW  <= 1'b0;
            memReadW   <= 1'b0;
            writeRegW  <= '0;
            aluResultW <= '0;
            readDataW  <= '0;
            pcW        <= '0;
        end else begin
            regWriteW  <= exMem_i.ctrl.regWrite;
            memReadW   <= exMem_i.ctrl.memRead;
            writeRegW  <= exMem_i.ctrl.writeReg;
            aluResultW <= exMem_i.aluResult;
            readDataW  <= dmemReadData_i;   // comb read captured here
            pcW        <= exMem_i.pc;
        end
    end

    assign wb.regWriteEn = regWriteW;
    assign wb.writeReg   = writeRegW;
    assign wb.writeData  = memReadW ? readDataW : aluResultW;
    assign wb.pc         = pcW;

endmodule

`default_nettype wire

// File: hw/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "mipsCore_macros.svh"

module hazardUnit (
    input  wire  [`REG_ADDR_W-1:0]      rsD_i,
    input  wire  [`REG_ADDR_W-1:0]      rtD_i,
    input  wire pipeCtrlPkg::idExT      idEx_i,
    input  wire pipeCtrlPkg::exMemT     exMem_i,
    wbIf.dst                            wb,
    output logic                        stall_o,
    output pipeCtrlPkg::fwdSelT         fwdA_o,
    output pipeCtrlPkg::fwdSelT         fwdB_o
);
    import pipeCtrlPkg::*;

    logic [`REG_ADDR_W-1:0] loadDest;

    // load in E, consumer in D: hold one cycle, then W forwarding covers it
    assign loadDest = idEx_i.ctrl.memRead ? idEx_i.ctrl.writeReg : '0;
    assign stall_o  = (loadDest != '0) && (loadDest == rsD_i || loadDest == rtD_i);

    // younger producer in M wins over W
    function automatic fwdSelT pickFwd(logic [`REG_ADDR_W-1:0] src,
                                       logic memWr, logic [`REG_ADDR_W-1:0] memReg,
                                       logic wbWr, logic [`REG_ADDR_W-1:0] wbReg);
        if (src == '0)
            return fwdNone;
        if (memWr && memReg == src)
            return fwdMem;
        if (wbWr && wbReg == src)
            return fwdWb;
        return fwdNone;
    endfunction

    assign fwdA_o = pickFwd(idEx_i.rs, exMem_i.ctrl.regWrite, exMem_i.ctrl.writeReg,
                            wb.regWriteEn, wb.writeReg);
    assign fwdB_o = pickFwd(idEx_i.rt, exMem_i.ctrl.regWrite, exMem_i.ctrl.writeReg,
                            wb.regWriteEn, wb.writeReg);

endmodule

`default_nettype wire

// File: hw/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none
`include "mipsCore_macros.svh"

module mipsCore (
    input  wire                         clk,
    input  wire                         rstN_i,
    output logic [`DATA_W-1:0]          imemAddr_o,
    input  wire  [`DATA_W-1:0]          imemData_i,
    output logic                        dmemEn_o,
    output logic                        dmemWe_o,
    output logic [`DATA_W-1:0]          dmemAddr_o,
    output logic [`DATA_W-1:0]          dmemWriteData_o,
    input  wire  [`DATA_W-1:0]          dmemReadData_i,
    output logic [`DATA_W-1:0]          pcW_o,
    output logic                        regWriteEnW_o,
    output logic [`REG_ADDR_W-1:0]      writeRegW_o,
    output logic [`DATA_W-1:0]          regWriteDataW_o
);
    import pipeCtrlPkg::*;

    idExT                   idEx;
    exMemT                  exMem;
    fwdSelT                 fwdA;
    fwdSelT                 fwdB;
    logic                   stall;
    logic [`REG_ADDR_W-1:0] rsD;
    logic [`REG_ADDR_W-1:0] rtD;

    wbIf wbBus ();

    fetchDecode fetchDecode_inst (
        .clk        (clk),
        .rstN_i     (rstN_i),
        .stall_i    (stall),
        .imemAddr_o (imemAddr_o),
        .imemData_i (imemData_i),
        .rsField_o  (rsD),
        .rtField_o  (rtD),
        .idEx_o     (idEx),
        .wb         (wbBus)
    );

    executeStage executeStage_inst (
        .clk      (clk),
        .rstN_i   (rstN_i),
        .idEx_i   (idEx),
        .fwdA_i   (fwdA),
        .fwdB_i   (fwdB),
        .wbData_i (wbBus.writeData),
        .exMem_o  (exMem)
    );

    memWbStage memWbStage_inst (
        .clk             (clk),
        .rstN_i          (rstN_i),
        .exMem_i         (exMem),
        .dmemEn_o        (dmemEn_o),
        .dmemWe_o        (dmemWe_o),
        .dmemAddr_o      (dmemAddr_o),
        .dmemWriteData_o (dmemWriteData_o),
        .dmemReadData_i  (dmemReadData_i),
        .wb              (wbBus)
    );

    hazardUnit hazardUnit_inst (
        .rsD_i   (rsD),
        .rtD_i   (rtD),
        .idEx_i  (idEx),
        .exMem_i (exMem),
        .wb      (wbBus),
        .stall_o (stall),
        .fwdA_o  (fwdA),
        .fwdB_o  (fwdB)
    );

    // retirement trace
    assign pcW_o           = wbBus.pc;
    assign regWriteEnW_o   = wbBus.regWriteEn;
    assign writeRegW_o     = wbBus.writeReg;
    assign regWriteDataW_o = wbBus.writeData;

endmodule

`default_nettype wire

// File: verification/mipsCore_properties.sv
`timescale 1ns/1ps
`default_nettype none
`include "mipsCore_macros.svh"

module mipsCore_properties (
    input wire                   clk,
    input wire                   rstN_i,
    input wire                   regWriteEnW_i,
    input wire [`REG_ADDR_W-1:0] writeRegW_i,
    input wire                   dmemEn_i,
    input wire                   dmemWe_i,
    input wire                   stall_i
);

    // r0 writes are dropped in decode
    regWriteNonZero: assert property (@(posedge clk) disable iff (!rstN_i)
        regWriteEnW_i |-> writeRegW_i != '0)
        else $error("trace write targets register zero");

    storeEnabled: assert property (@(posedge clk) disable iff (!rstN_i)
        dmemWe_i |-> dmemEn_i)
        else $error("data write enable without port enable");

    // bubble in E clears the load, so a stall lasts one cycle
    stallSingle: assert property (@(posedge clk) disable iff (!rstN_i)
        stall_i |=> !stall_i)
        else $error("stall held for two cycles");

    quietInReset: assert property (@(posedge clk)
        !rstN_i |-> !regWriteEnW_i && !dmemEn_i)
        else $error("trace write or memory access during reset");

endmodule

`default_nettype wire

// File: verification/mipsCoreTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "mipsCore_macros.svh"

module mipsCoreTb;
    import mipsIsaPkg::*;

    localparam int progLen       = 200;
    localparam int retireTimeout = 2000;   // cycles

    logic                   clk = 1'b0;
    logic                   rstN_i;
    logic [`DATA_W-1:0]     imemAddr;
    logic [`DATA_W-1:0]     imemData;
    logic                   dmemEn;
    logic                   dmemWe;
    logic [`DATA_W-1:0]     dmemAddr;
    logic [`DATA_W-1:0]     dmemWriteData;
    logic [`DATA_W-1:0]     dmemReadData;
    logic [`DATA_W-1:0]     pcW;
    logic                   regWriteEnW;
    logic [`REG_ADDR_W-1:0] writeRegW;
    logic [`DATA_W-1:0]     regWriteDataW;

    logic [`DATA_W-1:0]     imem [0:511];
    logic [`DATA_W-1:0]     dmem [0:15];      // 16-word data region

    // expected trace, stores and loads from the ISA model
    logic [`DATA_W-1:0]     expPc[$];
    logic [`REG_ADDR_W-1:0] expReg[$];
    logic [`DATA_W-1:0]     expVal[$];
    logic [`DATA_W-1:0]     expStAddr[$];
    logic [`DATA_W-1:0]     expStData[$];
    logic [`DATA_W-1:0]     expLdAddr[$];

    integer                 seed;
    int                     mismatches;
    int                     failures;
    int                     sinceRst;
    int                     waitCycles;
    logic                   seenWrite;
    logic [`DATA_W-1:0]     lastPc;

    mipsCore mipsCore_inst (
        .clk             (clk),
        .rstN_i          (rstN_i),
        .imemAddr_o      (imemAddr),
        .imemData_i      (imemData),
        .dmemEn_o        (dmemEn),
        .dmemWe_o        (dmemWe),
        .dmemAddr_o      (dmemAddr),
        .dmemWriteData_o (dmemWriteData),
        .dmemReadData_i  (dmemReadData),
        .pcW_o           (pcW),
        .regWriteEnW_o   (regWriteEnW),
        .writeRegW_o     (writeRegW),
        .regWriteDataW_o (regWriteDataW)
    );

    bind mipsCore mipsCore_properties mipsCore_properties_inst (
        .clk           (clk),
        .rstN_i        (rstN_i),
        .regWriteEnW_i (regWriteEnW_o),
        .writeRegW_i   (writeRegW_o),
        .dmemEn_i      (dmemEn_o),
        .dmemWe_i      (dmemWe_o),
        .stall_i       (stall)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    // combinational read ports, stores land at the edge
    assign imemData     = imem[imemAddr[10:2]];
    assign dmemReadData = dmem[dmemAddr[5:2]];

    always @(posedge clk) begin
        if (dmemWe) dmem[dmemAddr[5:2]] <= dmemWriteData;
    end

    function automatic int unsigned randBelow(input int unsigned n);
        int r;
        r = $random(seed);
        return $unsigned(r) % n;
    endfunction

    function automatic logic [`DATA_W-1:0] fillWord(input int idx);
        logic [`DATA_W-1:0] addr;
        addr = 32'(idx) << 2;
        return 32'h9e37_79b9 * (addr + 32'd1);
    endfunction

    // writes, stores and loads not yet seen on the ports
    function automatic int pendingCount();
        return expPc.size() + expStAddr.size() + expLdAddr.size();
    endfunction

    task automatic buildProgram();
        int unsigned            kind;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [4:0]             shamt;
        logic [15:0]            imm;
        logic [15:0]            off;
        logic [`DATA_W-1:0]     w;
        for (int i = 0; i < 512; i++) imem[i] = '0;   // nop tail
        for (int i = 0; i < 16; i++) dmem[i] = fillWord(i);
        for (int i = 0; i < progLen; i++) begin
            kind  = randBelow(13);
            rs    = 5'(32'd1 + randBelow(7));   // r1..r7 only
            rt    = 5'(32'd1 + randBelow(7));
            rd    = 5'(32'd1 + randBelow(7));
            shamt = 5'(randBelow(32));
            imm   = 16'(randBelow(65536));
            off   = 16'(randBelow(16) * 4);
            case (kind)
                0:       w = {opR, rs, rt, rd, 5'd0, fnAddu};
                1:       w = {opR, rs, rt, rd, 5'd0, fnSubu};
                2:       w = {opR, rs, rt, rd, 5'd0, fnAnd};
                3:       w = {opR, rs, rt, rd, 5'd0, fnOr};
                4:       w = {opR, rs, rt, rd, 5'd0, fnXor};
                5:       w = {opR, rs, rt, rd, 5'd0, fnSlt};
                6:       w = {opR, 5'd0, rt, rd, shamt, fnSll};
                7:       w = {opAddiu, rs, rt, imm};
                8:       w = {opAndi, rs, rt, imm};
                9:       w = {opOri, rs, rt, imm};
                10:      w = {opLui, 5'd0, rt, imm};
                11:      w = {opLw, 5'd0, rt, off};
                default: w = {opSw, 5'd0, rt, off};
            endcase
            imem[i] = w;
        end
    endtask

    // sequential ISA model, one instruction at a time
    task automatic runModel();
        logic [`DATA_W-1:0]     regs [0:31];
        logic [`DATA_W-1:0]     mem [0:15];
        logic [`DATA_W-1:0]     w;
        logic [`DATA_W-1:0]     a;
        logic [`DATA_W-1:0]     b;
        logic [`DATA_W-1:0]     sImm;
        logic [`DATA_W-1:0]     addr;
        logic [`DATA_W-1:0]     res;
        logic [`REG_ADDR_W-1:0] dst;
        logic                   wr;
        for (int k = 0; k < 32; k++) regs[k] = '0;
        for (int k = 0; k < 16; k++) mem[k] = fillWord(k);
        for (int i = 0; i < progLen; i++) begin
            w    = imem[i];
            a    = regs[w[25:21]];
            b    = regs[w[20:16]];
            sImm = {{16{w[15]}}, w[15:0]};
            addr = a + sImm;
            dst  = w[20:16];
            res  = '0;
            wr   = 1'b1;
            case (w[31:26])
                opR: begin
                    dst = w[15:11];
                    case (w[5:0])
                        fnAddu:  res = a + b;
                        fnSubu:  res = a - b;
                        fnAnd:   res = a & b;
                        fnOr:    res = a | b;
                        fnXor:   res = a ^ b;
                        fnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        fnSll:   res = b << w[10:6];
                        default: wr = 1'b0;
                    endcase
                end
                opAddiu: res = a + sImm;
                opAndi:  res = a & {16'h0000, w[15:0]};
                opOri:   res = a | {16'h0000, w[15:0]};
                opLui:   res = {w[15:0], 16'h0000};
                opLw: begin
                    res = mem[addr[5:2]];
                    expLdAddr.push_back(addr);
                end
                opSw: begin
                    wr = 1'b0;
                    mem[addr[5:2]] = b;
                    expStAddr.push_back(addr);
                    expStData.push_back(b);
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != '0) begin
                regs[dst] = res;
                expPc.push_back(32'(i) * 32'd4);
                expReg.push_back(dst);
                expVal.push_back(res);
            end
        end
    endtask

    // outputs are stable mid-cycle
    always @(negedge clk) begin
        if (!rstN_i) begin
            sinceRst = 0;
            if (imemAddr !== `RESET_PC) begin
                $display("mismatch imemAddr_o: got %h expected %h", imemAddr, `RESET_PC);
                mismatches++;
            end
            if (regWriteEnW !== 1'b0 || dmemEn !== 1'b0) begin
                $display("trace write or memory enable active during reset");
                failures++;
            end
        end else begin
            sinceRst++;
            if (sinceRst == 1 && imemAddr !== `RESET_PC) begin
                $display("mismatch imemAddr_o: got %h expected %h", imemAddr, `RESET_PC);
                mismatches++;
            end
            // nothing can reach M or W in the first cycles
            if (sinceRst <= 3 && (regWriteEnW !== 1'b0 || dmemEn !== 1'b0)) begin
                $display("trace write or memory enable before first possible retirement");
                failures++;
            end
            if (regWriteEnW === 1'b1) begin
                if (expPc.size() == 0) begin
                    $display("unexpected register write from pc %h", pcW);
                    failures++;
                end else begin
                    if (pcW !== expPc[0]) begin
                        $display("mismatch pcW_o: got %h expected %h", pcW, expPc[0]);
                        mismatches++;
                    end
                    if (writeRegW !== expReg[0]) begin
                        $display("mismatch writeRegW_o: got %h expected %h at pc %h",
                                 writeRegW, expReg[0], expPc[0]);
                        mismatches++;
                    end
                    if (regWriteDataW !== expVal[0]) begin
                        $display("mismatch regWriteDataW_o: got %h expected %h at pc %h",
                                 regWriteDataW, expVal[0], expPc[0]);
                        mismatches++;
                    end
                    void'(expPc.pop_front());
                    void'(expReg.pop_front());
                    void'(expVal.pop_front());
                end
                if (seenWrite && pcW <= lastPc) begin
                    $display("trace pc %h does not follow %h in program order", pcW, lastPc);
                    failures++;
                end
                seenWrite = 1'b1;
                lastPc    = pcW;
            end
            if (dmemWe === 1'b1) begin
                if (expStAddr.size() == 0) begin
                    $display("unexpected store to address %h", dmemAddr);
                    failures++;
                end else begin
                    if (dmemAddr !== expStAddr[0]) begin
                        $display("mismatch dmemAddr_o: got %h expected %h",
                                 dmemAddr, expStAddr[0]);
                        mismatches++;
                    end
                    if (dmemWriteData !== expStData[0]) begin
                        $display("mismatch dmemWriteData_o: got %h expected %h",
                                 dmemWriteData, expStData[0]);
                        mismatches++;
                    end
                    void'(expStAddr.pop_front());
                    void'(expStData.pop_front());
                end
            end
            // enable without write enable is a load in M
            if (dmemEn === 1'b1 && dmemWe !== 1'b1) begin
                if (expLdAddr.size() == 0) begin
                    $display("unexpected data read at address %h", dmemAddr);
                    failures++;
                end else begin
                    if (dmemAddr !== expLdAddr[0]) begin
                        $display("mismatch dmemAddr_o: got %h expected %h",
                                 dmemAddr, expLdAddr[0]);
                        mismatches++;
                    end
                    void'(expLdAddr.pop_front());
                end
            end
        end
    end

    initial begin
        rstN_i     = 1'b0;
        seed       = 67;
        mismatches = 0;
        failures   = 0;
        sinceRst   = 0;
        seenWrite  = 1'b0;
        lastPc     = '0;
        buildProgram();
        runModel();
        repeat (5) @(posedge clk);
        #5 rstN_i = 1'b1;
        waitCycles = 0;
        while (pendingCount() != 0 && waitCycles < retireTimeout) begin
            @(posedge clk);
            waitCycles++;
        end
        if (pendingCount() != 0) begin
            $display("timeout with %0d writes, %0d stores and %0d loads still missing",
                     expPc.size(), expStAddr.size(), expLdAddr.size());
            failures++;
        end
        repeat (8) @(posedge clk);   // let stray writes show up
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mipsCore.f
+incdir+hw
hw/mipsIsaPkg.sv
hw/pipeCtrlPkg.sv
hw/wbIf.sv
hw/fetchDecode.sv
hw/executeStage.sv
hw/memWbStage.sv
hw/hazardUnit.sv
hw/mipsCore.sv
verification/mipsCore_properties.sv
verification/mipsCoreTb.sv

// File: run.sh
#!/bin/sh
# build and run the mipsCore testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f mipsCore.f --top-module mipsCoreTb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/VmipsCoreTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Everything OK" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
